// File: zio_top.f
+incdir+include
logic/zx_bus_pkg.sv
logic/zx_cfg_pkg.sv
logic/zport_regs.sv
logic/zkbd_matrix.sv
logic/zio_readmux.sv
logic/zio_top.sv
testbench/tb_clkgen.sv
testbench/tb_zio_checker.sv
testbench/tb_zio_top.sv

// File: testbench/tb_zio_top.sv
`include "tune.svh"

module tb_zio_top;

	timeunit 1ns;
	timeprecision 100ps;

	import zx_bus_pkg::*;
	import zx_cfg_pkg::*;

	localparam int      N_OPS      = 2000;
	localparam longint  TIMEOUT_NS = N_OPS * 6 * 20 + 2000;

	logic        fclk;
	logic        reset;
	zbus_t       bus;
	logic        tape_in;
	logic        dos;
	kbd_matrix_t kbd_data;
	logic        kbd_stb;
	zdata_t      dout;
	logic        dout_ena;
	border_t     border;
	logic        beep;
	page_t       win0_page;
	page_t       win3_page;
	logic        win0_romnram;
	int          check_count;
	int          error_count;

	tb_clkgen u_clk (
		.fclk  (fclk),
		.reset (reset)
	);

	zio_top u_dut (
		.fclk         (fclk),
		.reset        (reset),
		.bus          (bus),
		.tape_in      (tape_in),
		.dos          (dos),
		.kbd_data     (kbd_data),
		.kbd_stb      (kbd_stb),
		.dout         (dout),
		.dout_ena     (dout_ena),
		.border       (border),
		.beep         (beep),
		.win0_page    (win0_page),
		.win3_page    (win3_page),
		.win0_romnram (win0_romnram)
	);

	tb_zio_checker #(
		.MEM_1024 (`TUNE_MEM_1024),
		.EFF7_EN  (`TUNE_EFF7_EN)
	) u_check (
		.fclk         (fclk),
		.reset        (reset),
		.bus          (bus),
		.tape_in      (tape_in),
		.dos          (dos),
		.kbd_data     (kbd_data),
		.kbd_stb      (kbd_stb),
		.dout         (dout),
		.dout_ena     (dout_ena),
		.border       (border),
		.beep         (beep),
		.win0_page    (win0_page),
		.win3_page    (win3_page),
		.win0_romnram (win0_romnram),
		.check_count  (check_count),
		.error_count  (error_count)
	);

	task automatic next_cycle();
		@(posedge fclk);
		#2;
	endtask

	task automatic drive_idle();
		bus.iorq_n = 1'b1;
		bus.rd_n   = 1'b1;
		bus.wr_n   = 1'b1;
		bus.m1_n   = 1'b1;
		kbd_stb    = 1'b0;
	endtask

	// #FE with a random upper byte, #7FFD, #EFF7 or anything
	function automatic zaddr_t pick_port();
		case ($urandom_range(3, 0))
			0: return {8'($urandom()), 8'hFE};
			1: return 16'h7FFD;
			2: return 16'hEFF7;
			default: return 16'($urandom());
		endcase
	endfunction

	task automatic write_port(int hold);
		bus.a    = pick_port();
		bus.d    = 8'($urandom());
		bus.iorq_n = 1'b0;
		bus.wr_n = 1'b0;
		repeat (hold)
		begin
			next_cycle();
			// new data while the level is held must be ignored
			bus.d = 8'($urandom());
		end
	endtask

	task automatic read_port(int hold);
		bus.a      = pick_port();
		bus.d      = 8'($urandom());
		bus.iorq_n = 1'b0;
		bus.rd_n   = 1'b0;
		repeat (hold) next_cycle();
	endtask

	task automatic int_ack(int hold);
		bus.a      = 16'($urandom());
		bus.iorq_n = 1'b0;
		bus.m1_n   = 1'b0;
		bus.rd_n   = 1'($urandom_range(1, 0));
		repeat (hold) next_cycle();
	endtask

	task automatic load_keyboard(int hold);
		logic [63:0] r;
		r = {$urandom(), $urandom()};
		kbd_data = r[39:0];
		kbd_stb  = 1'b1;
		next_cycle();
		kbd_stb  = 1'b0;
		repeat (hold - 1) next_cycle();
	endtask

	task automatic toggle_lines(int hold);
		tape_in = 1'($urandom_range(1, 0));
		dos     = 1'($urandom_range(1, 0));
		repeat (hold) next_cycle();
	endtask

	task automatic print_summary(int timeouts);
		$display("checks: %0d, mismatches: %0d, timeouts: %0d", check_count, error_count,
			timeouts);
	endtask

	initial
	begin
		int hold;
		void'($urandom(32'h2eb3_d949));
		bus      = '0;
		tape_in  = 1'b0;
		dos      = 1'b0;
		kbd_data = '1;
		drive_idle();

		@(negedge reset);
		for (int i = 0; i < N_OPS; i++)
		begin
			hold = $urandom_range(4, 2);
			case ($urandom_range(4, 0))
				0: write_port(hold);
				1: read_port(hold);
				2: int_ack(hold);
				3: load_keyboard(hold);
				default: toggle_lines(hold);
			endcase
			drive_idle();
			next_cycle();
		end

		repeat (3) next_cycle();
		print_summary(0);
		if (error_count == 0 && check_count > 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// watchdog
	initial
	begin
		#(TIMEOUT_NS * 1ns);
		$display("timeout: the random operations did not finish in time");
		print_summary(1);
		$display("test failed");
		$finish;
	end

endmodule

// File: testbench/tb_zio_checker.sv
module tb_zio_checker #(
	parameter bit MEM_1024 = 1'b1,
	parameter bit EFF7_EN  = 1'b1
) (
	input  logic                    fclk,
	input  logic                    reset,
	input  zx_bus_pkg::zbus_t       bus,
	input  logic                    tape_in,
	input  logic                    dos,
	input  zx_cfg_pkg::kbd_matrix_t kbd_data,
	input  logic                    kbd_stb,
	input  zx_bus_pkg::zdata_t      dout,
	input  logic                    dout_ena,
	input  zx_cfg_pkg::border_t     border,
	input  logic                    beep,
	input  zx_cfg_pkg::page_t       win0_page,
	input  zx_cfg_pkg::page_t       win3_page,
	input  logic                    win0_romnram,
	output int                      check_count,
	output int                      error_count
);

	timeunit 1ns;
	timeprecision 100ps;

	import zx_bus_pkg::*;
	import zx_cfg_pkg::*;

	logic [2:0]  m_border;
	logic        m_beep;
	logic [7:0]  m_p7ffd;
	logic [7:0]  m_peff7;
	logic [39:0] m_matrix;
	logic        m_wr_prev;
	logic [7:0]  m_dout;
	logic        m_dout_ena;
	logic        armed;
	logic        wr_level;
	logic        rd_level;
	logic [7:0]  exp_win0;
	logic [7:0]  exp_win3;

	initial
	begin
		check_count = 0;
		error_count = 0;
		armed       = 1'b0;
	end

	// AND of every half-row whose address line is low
	function automatic logic [4:0] selected_keys(logic [7:0] zah, logic [39:0] mat);
		logic [4:0] k;
		k = 5'h1F;
		for (int n = 0; n < 8; n++)
		begin
			if (!zah[n])
				k = k & mat[5*n +: 5];
		end
		return k;
	endfunction

	function automatic logic [7:0] read_value(logic [15:0] a);
		if (!a[0])
			return {1'b1, tape_in, 1'b1, selected_keys(a[15:8], m_matrix)};
		else if (EFF7_EN && a == 16'hEFF7)
			return m_peff7;
		else
			return 8'hFF;
	endfunction

	task automatic compare_value(string name, logic [7:0] expected, logic [7:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("Mismatch %s: expected %0h, actual %0h at %0t", name, expected, actual,
				$time);
		end
	endtask

	// model registers, inputs are stable at the edge
	always @(posedge fclk)
	begin
		if (reset)
		begin
			m_border   = '0;
			m_beep     = 1'b0;
			m_p7ffd    = '0;
			m_peff7    = '0;
			m_matrix   = '1;
			m_wr_prev  = 1'b0;
			m_dout     = '0;
			m_dout_ena = 1'b0;
			armed      = 1'b1;
		end
		else
		begin
			wr_level = !bus.iorq_n && !bus.wr_n;
			rd_level = !bus.iorq_n && !bus.rd_n && bus.m1_n;

			// read sees the state from before this edge
			if (rd_level)
				m_dout = read_value(bus.a);
			m_dout_ena = rd_level;

			if (wr_level && !m_wr_prev)
			begin
				if (!bus.a[0])
				begin
					m_border = bus.d[2:0];
					m_beep   = bus.d[4];
				end
				else if (!bus.a[1] && !bus.a[15])
				begin
					if (MEM_1024 || !m_p7ffd[5])
						m_p7ffd = bus.d;
				end
				else if (bus.a == 16'hEFF7)
				begin
					if (EFF7_EN)
						m_peff7 = bus.d;
				end
			end
			m_wr_prev = wr_level;

			if (kbd_stb)
				m_matrix = kbd_data;
		end
	end

	// outputs have settled by the falling edge
	always @(negedge fclk)
	begin
		if (armed)
		begin
			if (MEM_1024)
				exp_win3 = {2'b00, m_p7ffd[7:5], m_p7ffd[2:0]};
			else
				exp_win3 = {5'b00000, m_p7ffd[2:0]};

			if (m_peff7[3])
				exp_win0 = 8'h00;
			else
				exp_win0 = {6'b000000, ~dos, m_p7ffd[4]};

			compare_value("dout_ena", {7'b0, m_dout_ena}, {7'b0, dout_ena});
			if (m_dout_ena)
				compare_value("dout", m_dout, dout);
			compare_value("border", {5'b0, m_border}, {5'b0, border});
			compare_value("beep", {7'b0, m_beep}, {7'b0, beep});
			compare_value("win3_page", exp_win3, win3_page);
			compare_value("win0_page", exp_win0, win0_page);
			compare_value("win0_romnram", {7'b0, ~m_peff7[3]}, {7'b0, win0_romnram});
		end
	end

endmodule

// File: testbench/tb_clkgen.sv
module tb_clkgen #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 5
) (
	output logic fclk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		fclk = 1'b0;
		forever #(HALF_PERIOD) fclk = ~fclk;
	end

	// released just after an edge, like the other stimulus
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge fclk);
		#2 reset = 1'b0;
	end

endmodule

// File: logic/zio_top.sv
`include "tune.svh"

module zio_top #(
	parameter bit MEM_1024 = `TUNE_MEM_1024,
	parameter bit EFF7_EN  = `TUNE_EFF7_EN
) (
	input  logic                    fclk,
	input  logic                    reset,

	input  zx_bus_pkg::zbus_t       bus,
	input  logic                    tape_in,
	input  logic                    dos,

	// keyboard from the serial link
	input  zx_cfg_pkg::kbd_matrix_t kbd_data,
	input  logic                    kbd_stb,

	output zx_bus_pkg::zdata_t      dout,
	output logic                    dout_ena,

	output zx_cfg_pkg::border_t     border,
	output logic                    beep,

	output zx_cfg_pkg::page_t       win0_page,
	output zx_cfg_pkg::page_t       win3_page,
	output logic                    win0_romnram
);

	import zx_cfg_pkg::*;

	port_state_t state;
	kbd_row_t    keys;

	zport_regs #(
		.MEM_1024     (MEM_1024),
		.EFF7_EN      (EFF7_EN)
	) u_regs (
		.fclk         (fclk),
		.reset        (reset),
		.bus          (bus),
		.dos          (dos),
		.state        (state),
		.win0_page    (win0_page),
		.win3_page    (win3_page),
		.win0_romnram (win0_romnram)
	);

	zkbd_matrix u_kbd (
		.fclk         (fclk),
		.reset        (reset),
		.kbd_data     (kbd_data),
		.kbd_stb      (kbd_stb),
		.zah          (bus.a[15:8]),
		.keys         (keys)
	);

	zio_readmux #(
		.EFF7_EN      (EFF7_EN)
	) u_readmux (
		.fclk         (fclk),
		.reset        (reset),
		.bus          (bus),
		.state        (state),
		.keys         (keys),
		.tape_in      (tape_in),
		.dout         (dout),
		.dout_ena     (dout_ena)
	);

	assign border = state.border;
	assign beep   = state.beep;

endmodule

// File: logic/zio_readmux.sv
module zio_readmux #(
	parameter bit EFF7_EN = 1'b1
) (
	input  logic                    fclk,
	input  logic                    reset,

	input  zx_bus_pkg::zbus_t       bus,
	input  zx_cfg_pkg::port_state_t state,
	input  zx_cfg_pkg::kbd_row_t    keys,
	input  logic                    tape_in,

	output zx_bus_pkg::zdata_t      dout,
	output logic                    dout_ena
);

	import zx_bus_pkg::*;
	import zx_cfg_pkg::*;

	logic   rd_level;

	logic   sel_fe;
	logic   sel_eff7;

	zdata_t fe_data;
	zdata_t rd_data;

	// intack has m1 low and is filtered out here
	assign rd_level = io_read(bus);

	assign sel_fe   = is_port_fe(bus.a);
	assign sel_eff7 = EFF7_EN & is_port_eff7(bus.a);

	// bits 7 and 5 float high on the real machine
	assign fe_data = {1'b1, tape_in, 1'b1, keys};

	always_comb
	begin
		if (sel_fe)
			rd_data = fe_data;
		else if (sel_eff7)
			rd_data = state.peff7;
		else
			rd_data = 8'hFF;
	end

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			dout     <= '0;
			dout_ena <= 1'b0;
		end
		else
		begin
			dout_ena <= rd_level;

			// hold the last value between reads
			if (rd_level)
				dout <= rd_data;
		end
	end

endmodule

// File: logic/zkbd_matrix.sv
module zkbd_matrix (
	input  logic                    fclk,
	input  logic                    reset,

	input  zx_cfg_pkg::kbd_matrix_t kbd_data,
	input  logic                    kbd_stb,

	// upper half of the port address
	input  logic [7:0]              zah,

	output zx_cfg_pkg::kbd_row_t    keys
);

	import zx_cfg_pkg::*;

	kbd_matrix_t matrix;
	logic [KBD_ROWS-1:0] row_sel;

	// whole matrix arrives at once from the serial link
	always_ff @(posedge fclk)
	begin
		if (reset)
			matrix <= KBD_RELEASED;
		else if (kbd_stb)
			matrix <= kbd_data;
	end

	// a low address line selects its half-row
	assign row_sel = ~zah;

	always_comb
	begin
		keys = '1;

		for (int n = 0; n < KBD_ROWS; n++)
		begin
			if (row_sel[n])
				keys = keys & matrix[n];
		end
	end

endmodule

// File: logic/zport_regs.sv
module zport_regs #(
	parameter bit MEM_1024 = 1'b1,
	parameter bit EFF7_EN  = 1'b1
) (
	input  logic                    fclk,
	input  logic                    reset,

	input  zx_bus_pkg::zbus_t       bus,
	input  logic                    dos,

	output zx_cfg_pkg::port_state_t state,
	output zx_cfg_pkg::page_t       win0_page,
	output zx_cfg_pkg::page_t       win3_page,
	output logic                    win0_romnram
);

	import zx_bus_pkg::*;
	import zx_cfg_pkg::*;

	logic wr_level;
	logic wr_prev;
	logic wr_first;

	logic hit_fe;
	logic hit_7ffd;
	logic hit_eff7;

	logic lock_7ffd;

	logic ld_fe;
	logic ld_7ffd;
	logic ld_eff7;

	// only the first sampled cycle of a write counts
	assign wr_level = io_write(bus);
	assign wr_first = wr_level & ~wr_prev;

	always_ff @(posedge fclk)
	begin
		if (reset)
			wr_prev <= 1'b0;
		else
			wr_prev <= wr_level;
	end

	assign hit_fe   = is_port_fe(bus.a);
	assign hit_7ffd = is_port_7ffd(bus.a);
	assign hit_eff7 = is_port_eff7(bus.a);

	// 128K mode: bit 5 freezes #7FFD until reset
	assign lock_7ffd = ~MEM_1024 & state.p7ffd[P7FFD_LOCK];

	always_comb
	begin
		ld_fe   = 1'b0;
		ld_7ffd = 1'b0;
		ld_eff7 = 1'b0;

		if (wr_first)
		begin
			if (hit_fe)
				ld_fe = 1'b1;
			else if (hit_7ffd)
				ld_7ffd = ~lock_7ffd;
			else if (hit_eff7)
				ld_eff7 = EFF7_EN;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			state <= '0;
		end
		else
		begin
			if (ld_fe)
			begin
				state.border <= border_t'(bus.d[2:0]);
				state.beep   <= bus.d[4];
			end

			if (ld_7ffd)
				state.p7ffd <= bus.d;

			if (ld_eff7)
				state.peff7 <= bus.d;
		end
	end

	// page numbers for the memory windows
	always_comb
	begin
		if (MEM_1024)
			win3_page = {2'b00, state.p7ffd[7:5], state.p7ffd[2:0]};
		else
			win3_page = {5'b00000, state.p7ffd[2:0]};

		if (state.peff7[PEFF7_RAM0])
			win0_page = '0;
		else
			win0_page = {6'b000000, ~dos, state.p7ffd[P7FFD_ROM]};
	end

	// ram in window 0 replaces the rom
	assign win0_romnram = ~state.peff7[PEFF7_RAM0];

endmodule

// File: logic/zx_cfg_pkg.sv
package zx_cfg_pkg;

	localparam int KBD_ROWS = 8;

	typedef logic [7:0] page_t;
	typedef logic [2:0] border_t;

	// one half-row, a pressed key reads 0
	typedef logic [4:0] kbd_row_t;

	// row n answers to address line 8+n
	typedef kbd_row_t [KBD_ROWS-1:0] kbd_matrix_t;

	localparam kbd_matrix_t KBD_RELEASED = '1;

	typedef struct packed {
		border_t    border;
		logic       beep;
		logic [7:0] p7ffd;
		logic [7:0] peff7;
	} port_state_t;

	// p7ffd fields
	localparam int P7FFD_ROM  = 4;
	localparam int P7FFD_LOCK = 5;

	// peff7 bit that maps ram into window 0
	localparam int PEFF7_RAM0 = 3;

endpackage

// File: logic/zx_bus_pkg.sv
package zx_bus_pkg;

	typedef logic [15:0] zaddr_t;
	typedef logic [7:0]  zdata_t;

	// z80 bus as seen in the fclk domain, strobes active low
	typedef struct packed {
		zaddr_t a;
		zdata_t d;
		logic   iorq_n;
		logic   rd_n;
		logic   wr_n;
		logic   m1_n;
	} zbus_t;

	localparam zaddr_t PORT_EFF7 = 16'hEFF7;

	function automatic logic io_write(zbus_t b);
		return ~b.iorq_n & ~b.wr_n;
	endfunction

	// m1 low with iorq low is an interrupt acknowledge, never a read
	function automatic logic io_read(zbus_t b);
		return ~b.iorq_n & ~b.rd_n & b.m1_n;
	endfunction

	function automatic logic is_port_fe(zaddr_t a);
		return ~a[0];
	endfunction

	function automatic logic is_port_7ffd(zaddr_t a);
		return a[0] & ~a[1] & ~a[15];
	endfunction

	function automatic logic is_port_eff7(zaddr_t a);
		return a == PORT_EFF7;
	endfunction

endpackage

// File: include/tune.svh
`ifndef TUNE_SVH
`define TUNE_SVH

// 1024K paging through p7ffd bits 7..5
`define TUNE_MEM_1024 1'b1
`define TUNE_EFF7_EN  1'b1

`endif
